// ==== core_min.f ====
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/hazard_control.sv
hdl/core.sv
sim/core_mem_model.sv
sim/core_tb.sv

// ==== sim/core_cases.txt ====
# case <name>, w <instruction word>, g <expected gp>, m <byte address> <expected word>
# end runs the case; all values in hex
case arith
w 00c00093 w ffb00113 w 002081b3 w 40208233 w 0041c1b3 w 0011e1b3
w 0021f2b3 w 00112233 w 123450b7 w 0f02c193 w 1001e193 w 0ff1f293
w 0eb2a113 w 005081b3 w 002181b3 w 004181b3 w 00000073
g 123450ec
end
case store_load
w abcde137 w 12310113 w 04000093 w 0020a423 w 0080a183 w 00118213
w 0040a623 w 00c0a283 w 0050a823 w 00000073
g abcde123
m 00000048 abcde123 m 0000004c abcde124 m 00000050 abcde124
end
case dep_chain
w 00100193 w 003181b3 w 003181b3 w 00318193 w 003181b3 w fff1c193
w 403001b3 w 003181b3 w 00000073
g 0000001e
end
case branch_jal
w 00500093 w 00500113 w 00208663 w 11100193 w 22200193 w 00100193
w 00209463 w 00218193 w 00118463 w 00418193 w 00119663 w 10018193
w 20018193 w 00c002ef w 40018193 w 40018193 w 00818193 w 02502023
w 00000073
g 0000000f
m 00000020 00000038
end
case loop_rand_a
w 00400093 w 08000113 w 00000193 w 00012203 w 004181b3 w 04312023
w 00410113 w fff08093 w fe0096e3 w 00000073
g 68860086
m 000000c0 5a200020 m 000000c4 b4410041 m 000000c8 0e630063 m 000000cc 68860086
end
case loop_rand_b
w 00400093 w 08000113 w 00000193 w 00012203 w 004181b3 w 04312023
w 00410113 w fff08093 w fe0096e3 w 00000073
g 68860086
m 000000c0 5a200020 m 000000c4 b4410041 m 000000c8 0e630063 m 000000cc 68860086
end

// ==== sim/core_tb.sv ====
`default_nettype none

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS    = 256;
    localparam int EXIT_TIMEOUT = 5000;
    localparam int HALT_CYCLES  = 20;

    logic        clk;
    logic        rst_n;
    logic        inst_start;
    logic        inst_ready;
    logic [31:0] i_addr;
    logic [31:0] inst;
    logic        inst_valid;
    logic        d_cmd_start;
    logic        d_cmd_write;
    logic        d_cmd_ready;
    logic [31:0] d_addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        rdata_valid;
    logic        exit;
    logic [31:0] gp;

    // case read from the file
    logic [8*32-1:0] case_name;
    logic [31:0]     prog [MEM_WORDS];
    int              n_words;
    logic [31:0]     exp_gp;
    logic [31:0]     exp_addr [16];
    logic [31:0]     exp_data [16];
    int              n_exp;
    int              n_cases;
    int              n_failed;

    core uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_start  (inst_start),
        .inst_ready  (inst_ready),
        .i_addr      (i_addr),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .d_cmd_start (d_cmd_start),
        .d_cmd_write (d_cmd_write),
        .d_cmd_ready (d_cmd_ready),
        .d_addr      (d_addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .exit        (exit),
        .gp          (gp)
    );

    core_mem_model imem (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (inst_start),
        .write  (1'b0),
        .ready  (inst_ready),
        .addr   (i_addr),
        .wdata  (32'h0),
        .rdata  (inst),
        .rvalid (inst_valid)
    );

    core_mem_model dmem (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (d_cmd_start),
        .write  (d_cmd_write),
        .ready  (d_cmd_ready),
        .addr   (d_addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .rvalid (rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // addi x0, x0, idx
    function automatic logic [31:0] nop_at(input logic [7:0] idx);
        return {4'h0, idx, 20'h0_0013};
    endfunction

    function automatic logic [31:0] fill_at(input logic [7:0] idx);
        return {8'h5a, idx, 8'h00, idx};
    endfunction

    task automatic reset_and_load;
        int i;
        @(negedge clk);
        rst_n = 1'b0;
        for (i = 0; i < MEM_WORDS; i++) begin
            imem.mem[i] = (i < n_words) ? prog[i] : nop_at(i[7:0]);
            dmem.mem[i] = fill_at(i[7:0]);
        end
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // ******************************************************************
    // one program from reset to halt
    // ******************************************************************

    task automatic run_case;
        int          errs;
        int          cycles;
        int          k;
        logic [31:0] got;
        errs = 0;
        reset_and_load();
        @(negedge clk);
        if (exit !== 1'b0) begin
            $display("error: exit = %h, expected 0", exit);
            errs++;
        end
        cycles = 0;
        while (exit !== 1'b1 && cycles < EXIT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (exit !== 1'b1) begin
            $display("case %0s: timed out, exit never rose in %0d cycles",
                     case_name, EXIT_TIMEOUT);
            errs++;
        end else begin
            // halted core stays quiet
            for (k = 0; k < HALT_CYCLES; k++) begin
                @(posedge clk);
                if (inst_start) begin
                    $display("case %0s: instruction fetch started after exit", case_name);
                    errs++;
                end
                @(negedge clk);
                if (exit !== 1'b1) begin
                    $display("error: exit = %h, expected 1", exit);
                    errs++;
                end
            end
            if (gp !== exp_gp) begin
                $display("error: gp = %h, expected %h", gp, exp_gp);
                errs++;
            end
            for (k = 0; k < n_exp; k++) begin
                got = dmem.mem[exp_addr[k][9:2]];
                if (got !== exp_data[k]) begin
                    $display("error: dmem[%h] = %h, expected %h", exp_addr[k], got, exp_data[k]);
                    errs++;
                end
            end
        end
        n_cases++;
        if (errs == 0) begin
            $display("case %0s: ok, exit after %0d cycles", case_name, cycles);
        end else begin
            n_failed++;
            $display("case %0s: %0d errors", case_name, errs);
        end
    endtask

    initial begin : main
        int               fd;
        int               r;
        bit               bad_file;
        bit               in_case;
        logic [8*32-1:0]  kw;
        logic [8*128-1:0] line;
        logic [31:0]      v0;
        logic [31:0]      v1;
        rst_n    = 1'b0;
        n_cases  = 0;
        n_failed = 0;
        n_words  = 0;
        n_exp    = 0;
        exp_gp   = '0;
        bad_file = 1'b0;
        in_case  = 1'b0;
        fd = $fopen("sim/core_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/core_cases.txt");
            bad_file = 1'b1;
        end
        while (!bad_file && $fscanf(fd, "%s", kw) == 1) begin
            if (kw == "#") begin
                r = $fgets(line, fd);
            end else if (kw == "case") begin
                r = $fscanf(fd, "%s", case_name);
                n_words = 0;
                n_exp   = 0;
                in_case = 1'b1;
            end else if (kw == "w") begin
                r = $fscanf(fd, "%h", v0);
                if (r != 1 || n_words >= MEM_WORDS) begin
                    bad_file = 1'b1;
                end else begin
                    prog[n_words] = v0;
                    n_words++;
                end
            end else if (kw == "g") begin
                r = $fscanf(fd, "%h", exp_gp);
                bad_file = (r != 1);
            end else if (kw == "m") begin
                r = $fscanf(fd, "%h %h", v0, v1);
                if (r != 2 || n_exp >= 16) begin
                    bad_file = 1'b1;
                end else begin
                    exp_addr[n_exp] = v0;
                    exp_data[n_exp] = v1;
                    n_exp++;
                end
            end else if (kw == "end") begin
                run_case();
                in_case = 1'b0;
            end else begin
                bad_file = 1'b1;
            end
            if (bad_file) begin
                $display("cases file has a bad entry at keyword %0s", kw);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (in_case && !bad_file) begin
            $display("cases file ends inside case %0s", case_name);
            bad_file = 1'b1;
        end
        $display("%0d cases run, %0d passed, %0d failed",
                 n_cases, n_cases - n_failed, n_failed);
        if (!bad_file && n_cases > 0 && n_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/core_mem_model.sv ====
`default_nettype none

module core_mem_model (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         start,
    input  wire         write,
    output logic        ready,
    input  wire  [31:0] addr,
    input  wire  [31:0] wdata,
    output logic [31:0] rdata,
    output logic        rvalid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [256];
    logic [31:0] lfsr;
    logic        req_seen;
    logic        req_write;
    logic [7:0]  req_idx;
    int          left;
    logic        rd_pend;

    // galois form, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // extra wait of 0 to 3 cycles, one lfsr step per bit
    task automatic draw_delay(output int d);
        int b;
        d = 0;
        for (b = 0; b < 2; b++) begin
            lfsr = lfsr_next(lfsr);
            d = d | (int'(lfsr[0]) << b);
        end
    endtask

    initial begin
        lfsr     = 32'h884c;
        ready    = 1'b0;
        rvalid   = 1'b0;
        rdata    = '0;
        left     = 0;
        rd_pend  = 1'b0;
        req_seen = 1'b0;
    end

    // handshake taken at the rising edge, stores land here too
    always @(posedge clk) begin
        req_seen <= rst_n && start && ready;
        if (rst_n && start && ready) begin
            req_write <= write;
            req_idx   <= addr[9:2];
            if (write) begin
                mem[addr[9:2]] <= wdata;
            end
        end
    end

    // responses change on the falling edge
    always @(negedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left    = 0;
            rd_pend = 1'b0;
            ready  <= 1'b1;
            rvalid <= 1'b0;
        end else begin
            if (req_seen) begin
                draw_delay(left);
                rd_pend = !req_write;
            end
            if (rd_pend && left == 0) begin
                rvalid <= 1'b1;
                rdata  <= mem[req_idx];
                ready  <= 1'b0;
                rd_pend = 1'b0;
            end else begin
                rvalid <= 1'b0;
                ready  <= !rd_pend && left == 0;
                if (left > 0) begin
                    left = left - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/core.sv ====
`default_nettype none

module core (
    input  wire         clk,
    input  wire         rst_n,
    output logic        inst_start,
    input  wire         inst_ready,
    output logic [31:0] i_addr,
    input  wire  [31:0] inst,
    input  wire         inst_valid,
    output logic        d_cmd_start,
    output logic        d_cmd_write,
    input  wire         d_cmd_ready,
    output logic [31:0] d_addr,
    output logic [31:0] wdata,
    input  wire  [31:0] rdata,
    input  wire         rdata_valid,
    output logic        exit,
    output logic [31:0] gp
);
    import pipe_pkg::*;

    fd_t         fd;
    de_t         de;
    em_t         em;
    wb_t         wb;
    hazard_req_t hreq;
    stage_ctl_t  ctl;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic        mem_busy;

    // ******************************************************************
    // stages
    // ******************************************************************

    fetch_stage u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctl         (ctl),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst_start  (inst_start),
        .inst_ready  (inst_ready),
        .i_addr      (i_addr),
        .inst        (inst),
        .inst_valid  (inst_valid),
        .fd          (fd)
    );

    decode_stage u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .fd    (fd),
        .ctl   (ctl),
        .wb    (wb),
        .de    (de),
        .hreq  (hreq),
        .gp    (gp)
    );

    execute_stage u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .de          (de),
        .mem_busy    (mem_busy),
        .em          (em),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    memory_stage u_memory (
        .clk         (clk),
        .rst_n       (rst_n),
        .em          (em),
        .d_cmd_start (d_cmd_start),
        .d_cmd_write (d_cmd_write),
        .d_cmd_ready (d_cmd_ready),
        .d_addr      (d_addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .mem_busy    (mem_busy),
        .wb          (wb)
    );

    // stall, flush and halt
    hazard_control u_hazard (
        .clk      (clk),
        .rst_n    (rst_n),
        .hreq     (hreq),
        .de       (de),
        .em       (em),
        .wb       (wb),
        .redirect (redirect),
        .mem_busy (mem_busy),
        .ctl      (ctl),
        .exit     (exit)
    );

endmodule

`default_nettype wire

// ==== hdl/hazard_control.sv ====
`default_nettype none

module hazard_control (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire pipe_pkg::hazard_req_t hreq,
    input  wire pipe_pkg::de_t         de,
    input  wire pipe_pkg::em_t         em,
    input  wire pipe_pkg::wb_t         wb,
    input  wire                        redirect,
    input  wire                        mem_busy,
    output pipe_pkg::stage_ctl_t       ctl,
    output logic                       exit
);

    logic hazard;
    logic ecall_busy;
    logic hold_d;

    // register still waiting for writeback somewhere downstream
    function automatic logic pending(input logic [4:0] rs);
        return (rs != 5'd0)
            && ((de.valid && de.rf_wen && de.rd == rs)
             || (em.valid && em.rf_wen && em.rd == rs)
             || (wb.valid && wb.rf_wen && wb.rd == rs));
    endfunction

    assign hazard = hreq.valid
                 && ((hreq.uses_rs1 && pending(hreq.rs1))
                  || (hreq.uses_rs2 && pending(hreq.rs2)));

    // nothing younger than an ecall may issue
    assign ecall_busy = (de.valid && de.is_ecall)
                     || (em.valid && em.is_ecall)
                     || (wb.valid && wb.is_ecall);

    assign hold_d = hazard || ecall_busy || exit;

    // busy memory freezes de in place, a hold in decode leaves a bubble
    assign ctl.stall_d = hold_d || mem_busy;
    assign ctl.flush_d = redirect || (hold_d && !mem_busy);
    assign ctl.stall_f = ctl.stall_d || mem_busy || exit;
    assign ctl.flush_f = redirect;
    assign ctl.halt    = exit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exit <= 1'b0;
        end else if (wb.valid && wb.is_ecall) begin
            exit <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/memory_stage.sv ====
`default_nettype none

module memory_stage (
    input  wire                clk,
    input  wire                rst_n,
    input  wire pipe_pkg::em_t em,
    output logic               d_cmd_start,
    output logic               d_cmd_write,
    input  wire                d_cmd_ready,
    output logic [31:0]        d_addr,
    output logic [31:0]        wdata,
    input  wire  [31:0]        rdata,
    input  wire                rdata_valid,
    output logic               mem_busy,
    output pipe_pkg::wb_t      wb
);

    typedef enum logic {
        M_IDLE,
        M_READ
    } mstate_t;

    mstate_t     state;
    logic        is_mem;
    logic        done;
    logic [31:0] wb_data;

    assign is_mem      = em.valid && (em.is_load || em.is_store);
    assign d_cmd_start = is_mem && (state == M_IDLE) && d_cmd_ready;
    assign d_cmd_write = em.is_store;
    assign d_addr      = em.alu_out;
    assign wdata       = em.rs2_data;

    // store ends when accepted, load when its data comes back
    assign done = (state == M_IDLE && em.is_store && d_cmd_ready)
               || (state == M_READ && rdata_valid);
    assign mem_busy = is_mem && !done;

    always_comb begin
        if (em.is_load) begin
            wb_data = rdata;
        end else if (em.is_jal) begin
            wb_data = em.link_pc;
        end else begin
            wb_data = em.alu_out;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= M_IDLE;
            wb    <= '0;
        end else begin
            case (state)
                M_IDLE:  if (d_cmd_start && !d_cmd_write) state <= M_READ;
                M_READ:  if (rdata_valid) state <= M_IDLE;
                default: state <= M_IDLE;
            endcase
            // bubble while the access is pending
            wb.valid    <= em.valid && !mem_busy;
            wb.rf_wen   <= em.rf_wen;
            wb.rd       <= em.rd;
            wb.data     <= wb_data;
            wb.is_ecall <= em.is_ecall;
        end
    end

    a_read_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == M_READ |-> em.valid && em.is_load && $stable(em)
    ) else $error("load left the memory stage before its read data returned");

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`default_nettype none

module execute_stage (
    input  wire                clk,
    input  wire                rst_n,
    input  wire pipe_pkg::de_t de,
    input  wire                mem_busy,
    output pipe_pkg::em_t      em,
    output logic               redirect,
    output logic [31:0]        redirect_pc
);
    import isa_pkg::*;

    logic [31:0] alu_res;
    logic        taken;

    always_comb begin
        case (de.alu_op)
            ALU_SUB:    alu_res = de.op_a - de.op_b;
            ALU_AND:    alu_res = de.op_a & de.op_b;
            ALU_OR:     alu_res = de.op_a | de.op_b;
            ALU_XOR:    alu_res = de.op_a ^ de.op_b;
            ALU_SLT:    alu_res = {31'd0, $signed(de.op_a) < $signed(de.op_b)};
            ALU_PASS_B: alu_res = de.op_b;
            default:    alu_res = de.op_a + de.op_b;
        endcase
    end

    // beq or bne, jal always taken
    assign taken = de.is_jal || (de.is_branch && ((de.op_a == de.op_b) != de.branch_ne));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            em          <= '0;
            redirect    <= 1'b0;
            redirect_pc <= '0;
        end else if (!mem_busy) begin
            // the instruction behind a redirect is on the wrong path
            em.valid    <= de.valid && !redirect;
            em.alu_out  <= alu_res;
            em.rs2_data <= de.rs2_data;
            em.is_load  <= de.is_load;
            em.is_store <= de.is_store;
            em.is_jal   <= de.is_jal;
            em.is_ecall <= de.is_ecall;
            em.rf_wen   <= de.rf_wen;
            em.rd       <= de.rd;
            em.link_pc  <= de.pc + 32'd4;
            redirect    <= de.valid && !redirect && taken;
            redirect_pc <= de.pc + de.imm;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`default_nettype none

`include "core_params.svh"

module decode_stage (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire pipe_pkg::fd_t        fd,
    input  wire pipe_pkg::stage_ctl_t ctl,
    input  wire pipe_pkg::wb_t        wb,
    output pipe_pkg::de_t             de,
    output pipe_pkg::hazard_req_t     hreq,
    output logic [31:0]               gp
);
    import isa_pkg::*;
    import pipe_pkg::*;

    inst_u       ir;
    logic [31:0] regs [`CORE_NREGS];
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    alu_op_t     f3_op;
    logic        use1;
    logic        use2;
    de_t         nxt;

    assign ir       = fd.inst;
    assign rs1_data = regs[ir.r_fmt.rs1];
    assign rs2_data = regs[ir.r_fmt.rs2];
    assign gp       = regs[`CORE_GP_REG];

    // ******************************************************************
    // immediates
    // ******************************************************************

    assign imm_i = {{20{ir.i_fmt.imm[11]}}, ir.i_fmt.imm};
    assign imm_s = {{20{ir.s_fmt.imm_hi[6]}}, ir.s_fmt.imm_hi, ir.s_fmt.imm_lo};
    assign imm_b = {{19{ir.b_fmt.imm12}}, ir.b_fmt.imm12, ir.b_fmt.imm11,
                    ir.b_fmt.imm10_5, ir.b_fmt.imm4_1, 1'b0};
    assign imm_u = {ir.u_fmt.imm, 12'h000};
    assign imm_j = {{11{ir.j_fmt.imm20}}, ir.j_fmt.imm20, ir.j_fmt.imm19_12,
                    ir.j_fmt.imm11, ir.j_fmt.imm10_1, 1'b0};

    // ******************************************************************
    // control decode
    // ******************************************************************

    always_comb begin
        case (ir.i_fmt.funct3)
            F3_SLT:  f3_op = ALU_SLT;
            F3_XOR:  f3_op = ALU_XOR;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
            default: f3_op = ALU_ADD;
        endcase
    end

    always_comb begin
        nxt          = '0;
        nxt.valid    = fd.valid;
        nxt.pc       = fd.pc;
        nxt.op_a     = rs1_data;
        nxt.op_b     = rs2_data;
        nxt.rs2_data = rs2_data;
        nxt.imm      = imm_i;
        nxt.rd       = ir.r_fmt.rd;
        nxt.alu_op   = ALU_ADD;
        use1         = 1'b0;
        use2         = 1'b0;
        case (ir.r_fmt.opcode)
            OPC_OP: begin
                use1       = 1'b1;
                use2       = 1'b1;
                nxt.rf_wen = 1'b1;
                // funct7 bit 5 selects sub
                if (ir.r_fmt.funct3 == F3_ADD && ir.r_fmt.funct7[5]) begin
                    nxt.alu_op = ALU_SUB;
                end else begin
                    nxt.alu_op = f3_op;
                end
            end
            OPC_OP_IMM: begin
                use1       = 1'b1;
                nxt.op_b   = imm_i;
                nxt.alu_op = f3_op;
                nxt.rf_wen = 1'b1;
            end
            OPC_LUI: begin
                nxt.op_b   = imm_u;
                nxt.alu_op = ALU_PASS_B;
                nxt.rf_wen = 1'b1;
            end
            OPC_LOAD: begin
                use1        = 1'b1;
                nxt.op_b    = imm_i;
                nxt.is_load = 1'b1;
                nxt.rf_wen  = 1'b1;
            end
            OPC_STORE: begin
                use1         = 1'b1;
                use2         = 1'b1;
                nxt.op_b     = imm_s;
                nxt.is_store = 1'b1;
            end
            OPC_BRANCH: begin
                use1          = 1'b1;
                use2          = 1'b1;
                nxt.imm       = imm_b;
                nxt.is_branch = 1'b1;
                nxt.branch_ne = ir.b_fmt.funct3[0];
            end
            OPC_JAL: begin
                nxt.imm    = imm_j;
                nxt.is_jal = 1'b1;
                nxt.rf_wen = 1'b1;
            end
            OPC_SYSTEM: nxt.is_ecall = 1'b1;
            default: ;
        endcase
        // x0 never written
        if (nxt.rd == 5'd0) begin
            nxt.rf_wen = 1'b0;
        end
    end

    assign hreq = '{valid: fd.valid, rs1: ir.r_fmt.rs1, rs2: ir.r_fmt.rs2,
                    uses_rs1: use1, uses_rs2: use2};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            de <= '0;
        end else if (ctl.flush_d) begin
            de <= '0;
        end else if (!ctl.stall_d) begin
            de <= nxt;
        end
    end

    // register file with writeback from the memory stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rf_wen) begin
            regs[wb.rd] <= wb.data;
        end
    end

    a_x0_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        regs[0] == '0
    ) else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`default_nettype none

`include "core_params.svh"

module fetch_stage (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire pipe_pkg::stage_ctl_t ctl,
    input  wire                     redirect,
    input  wire  [31:0]             redirect_pc,
    output logic                    inst_start,
    input  wire                     inst_ready,
    output logic [31:0]             i_addr,
    input  wire  [31:0]             inst,
    input  wire                     inst_valid,
    output pipe_pkg::fd_t           fd
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_WAIT,
        F_DISCARD
    } fstate_t;

    fstate_t     state;
    logic [31:0] pc;
    logic        take;

    // pc holds the address of the outstanding request until it returns
    assign inst_start = (state == F_IDLE) && inst_ready && !ctl.stall_f && !ctl.halt
                        && !redirect;
    assign i_addr     = pc;
    assign take       = (state == F_WAIT) && inst_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= F_IDLE;
            pc    <= `CORE_RESET_PC;
            fd    <= '0;
        end else begin
            case (state)
                F_IDLE:    if (inst_start) state <= F_WAIT;
                F_WAIT:    if (inst_valid) state <= F_IDLE;
                           else if (redirect) state <= F_DISCARD;
                F_DISCARD: if (inst_valid) state <= F_IDLE;
                default:   state <= F_IDLE;
            endcase

            if (redirect) begin
                pc <= redirect_pc;
            end else if (take) begin
                pc <= pc + 32'd4;
            end

            // fd is always empty when a response comes back
            if (ctl.flush_f) begin
                fd.valid <= 1'b0;
            end else if (take) begin
                fd.valid <= 1'b1;
                fd.pc    <= pc;
                fd.inst  <= inst;
            end else if (!ctl.stall_d) begin
                fd.valid <= 1'b0;
            end
        end
    end

    a_one_outstanding: assert property (
        @(posedge clk) disable iff (!rst_n)
        inst_start |=> !inst_start until inst_valid
    ) else $error("inst_start while a fetch is outstanding");

endmodule

`default_nettype wire

// ==== hdl/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;
    import isa_pkg::*;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        inst_u       inst;
    } fd_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] rs2_data;
        logic [31:0] imm;
        alu_op_t     alu_op;
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        logic        branch_ne;
        logic        is_jal;
        logic        is_ecall;
        logic        rf_wen;
        logic [4:0]  rd;
    } de_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] alu_out;
        logic [31:0] rs2_data;
        logic        is_load;
        logic        is_store;
        logic        is_jal;
        logic        is_ecall;
        logic        rf_wen;
        logic [4:0]  rd;
        logic [31:0] link_pc;
    } em_t;

    typedef struct packed {
        logic        valid;
        logic        rf_wen;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        is_ecall;
    } wb_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       uses_rs1;
        logic       uses_rs2;
    } hazard_req_t;

    typedef struct packed {
        logic stall_f;
        logic flush_f;
        logic stall_d;
        logic flush_d;
        logic halt;
    } stage_ctl_t;

endpackage

`default_nettype wire

// ==== hdl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    // funct3 of register and immediate arithmetic
    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    // ******************************************************************
    // instruction formats, all views of the same word
    // ******************************************************************

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_t    funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        funct3_t     funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_t    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

endpackage

`default_nettype wire

// ==== hdl/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// architectural register count
`define CORE_NREGS 32

// register shown on the gp port
`define CORE_GP_REG 3

`endif
